// File: rtl/clk_ctrl_pkg.sv
// **************************************************
// clock management unit shared definitions
// source count, monitor window, command opcodes
// and the command and status structs
// **************************************************
package clk_ctrl_pkg;

  // number of source clocks, source 0 is the reference
  localparam int CLK_NUM = 4;
  // width of a source index
  localparam int SEL_W = $clog2(CLK_NUM);

  // reference cycles without a source edge before a fault
  localparam int FAIL_WINDOW = 16;
  // monitor counter sized to hold the full window
  localparam int FAIL_CNT_W = $clog2(FAIL_WINDOW + 1);
  localparam logic [FAIL_CNT_W-1:0] FAIL_LIMIT = FAIL_CNT_W'(FAIL_WINDOW);

  // command opcodes, codes 5..7 reserved
  typedef enum logic [2:0] {
    OP_NOP        = 3'd0,
    OP_SELECT     = 3'd1,
    OP_AUTO_ON    = 3'd2,
    OP_AUTO_OFF   = 3'd3,
    OP_CLEAR_FAIL = 3'd4
  } clk_op_e;

  // one command word, sampled with cmd_valid
  typedef struct packed {
    clk_op_e          op;
    logic [SEL_W-1:0] src;
  } clk_cmd_t;

  // status word seen from outside
  typedef struct packed {
    logic [SEL_W-1:0]   active;
    logic [SEL_W-1:0]   req;
    logic [CLK_NUM-1:0] fail;
    logic               auto_en;
    logic               bad_op;
  } clk_status_t;

endpackage

// File: rtl/rst_sync_bank.sv
// **************************************************
// reset synchronizer bank
// one async-assert, sync-release pair of flops per
// source clock domain
// **************************************************
module rst_sync_bank (
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] i_clk,
  input  logic                             rst_n,
  output logic [clk_ctrl_pkg::CLK_NUM-1:0] src_rst_n
);

  for (genvar k = 0; k < clk_ctrl_pkg::CLK_NUM; k++) begin : g_sync
    // shift a one in after reset lifts
    logic [1:0] sync_q;

    always_ff @(posedge i_clk[k] or negedge rst_n) begin
      if (!rst_n) begin
        sync_q <= 2'b00;
      end else begin
        sync_q <= {sync_q[0], 1'b1};
      end
    end

    // released on the second edge of this source
    assign src_rst_n[k] = sync_q[1];
  end

endmodule

// File: rtl/clk_cmd_decode.sv
// **************************************************
// command decoder
// turns command strobes into the requested source,
// the failover enable and fault-clear pulses
// **************************************************
module clk_cmd_decode (
  input  logic                             i_clk0,
  input  logic                             rst_n,
  input  clk_ctrl_pkg::clk_cmd_t           cmd,
  input  logic                             cmd_valid,
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] clk_fail,
  output logic [clk_ctrl_pkg::SEL_W-1:0]   sel,
  output logic                             auto_en,
  output logic                             clear_fail,
  output logic                             bad_op
);

  // requested source has a fault and failover is armed
  logic failover;

  // bit 0 of clk_fail is tied low, so sel of 0 never trips
  assign failover = auto_en & clk_fail[sel];

  // **************************************************
  // command register
  // **************************************************
  always_ff @(posedge i_clk0 or negedge rst_n) begin
    if (!rst_n) begin
      sel        <= '0;
      auto_en    <= 1'b0;
      clear_fail <= 1'b0;
      bad_op     <= 1'b0;
    end else begin
      // single cycle pulse by default
      clear_fail <= 1'b0;

      // fall back to the reference
      if (failover) begin
        sel <= '0;
      end

      // an explicit select in the same cycle wins,
      // failover rechecks it on the next cycle
      if (cmd_valid) begin
        case (cmd.op)
          clk_ctrl_pkg::OP_NOP: begin
          end
          clk_ctrl_pkg::OP_SELECT: begin
            sel <= cmd.src;
          end
          clk_ctrl_pkg::OP_AUTO_ON: begin
            auto_en <= 1'b1;
          end
          clk_ctrl_pkg::OP_AUTO_OFF: begin
            auto_en <= 1'b0;
          end
          clk_ctrl_pkg::OP_CLEAR_FAIL: begin
            clear_fail <= 1'b1;
            bad_op     <= 1'b0;
          end
          default: begin
            // reserved code, request left alone
            bad_op <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

// File: rtl/clk_fail_monitor.sv
// **************************************************
// clock loss monitor
// counts reference cycles between synchronized
// toggles of each source and flags a stopped clock
// **************************************************
module clk_fail_monitor (
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] i_clk,
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] src_rst_n,
  input  logic                             rst_n,
  input  logic                             clear_fail,
  output logic [clk_ctrl_pkg::CLK_NUM-1:0] clk_fail
);

  // reference can't be watched against itself
  assign clk_fail[0] = 1'b0;

  for (genvar k = 1; k < clk_ctrl_pkg::CLK_NUM; k++) begin : g_mon
    // divide-by-two of the watched source
    logic                                tgl;
    // two sync stages plus one for edge detect
    logic [2:0]                          tgl_sync;
    // a source edge arrived in the reference domain
    logic                                seen;
    logic [clk_ctrl_pkg::FAIL_CNT_W-1:0] cnt;
    logic                                fail_q;

    // **************************************************
    // source domain
    // **************************************************
    always_ff @(posedge i_clk[k] or negedge src_rst_n[k]) begin
      if (!src_rst_n[k]) begin
        tgl <= 1'b0;
      end else begin
        tgl <= ~tgl;
      end
    end

    // **************************************************
    // reference domain
    // **************************************************
    always_ff @(posedge i_clk[0] or negedge rst_n) begin
      if (!rst_n) begin
        tgl_sync <= 3'b000;
      end else begin
        tgl_sync <= {tgl_sync[1:0], tgl};
      end
    end

    assign seen = tgl_sync[2] ^ tgl_sync[1];

    // window counter, saturates at the limit
    always_ff @(posedge i_clk[0] or negedge rst_n) begin
      if (!rst_n) begin
        cnt    <= '0;
        fail_q <= 1'b0;
      end else begin
        if (seen || clear_fail) begin
          cnt <= '0;
        end else if (cnt != clk_ctrl_pkg::FAIL_LIMIT) begin
          cnt <= cnt + 1'b1;
        end
        // sticky until cleared; rises as cnt hits the limit
        if (clear_fail) begin
          fail_q <= 1'b0;
        end else if (!seen && cnt == clk_ctrl_pkg::FAIL_LIMIT - 1'b1) begin
          fail_q <= 1'b1;
        end
      end
    end

    assign clk_fail[k] = fail_q;
  end

endmodule

// File: rtl/sys_clk_switch.sv
// **************************************************
// glitch-free clock switch
// sel may change at any time; each enable syncs on
// its own clock, all in reset gives i_clk[0]
// **************************************************
module sys_clk_switch (
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] i_clk,
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] clk_fail,
  input  logic [clk_ctrl_pkg::SEL_W-1:0]   sel,
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] src_rst_n,
  output logic                             o_clk,
  output logic [clk_ctrl_pkg::CLK_NUM-1:0] active
);

  // decoded sel
  logic [clk_ctrl_pkg::CLK_NUM-1:0] onehot_sel;
  // enable request into each first stage
  logic [clk_ctrl_pkg::CLK_NUM-1:0] req;
  // any enable set other than the selected one
  logic                             others_on;

  // **************************************************
  // request logic
  // **************************************************
  always_comb begin
    onehot_sel      = '0;
    onehot_sel[sel] = 1'b1;
  end

  // masking with ~onehot_sel drops the selected bit
  assign others_on = |(active & ~onehot_sel);

  // new source waits for every other enable to fall
  assign req = onehot_sel & {clk_ctrl_pkg::CLK_NUM{~others_on}};

  // **************************************************
  // two-stage enable per source
  // **************************************************
  for (genvar k = 0; k < clk_ctrl_pkg::CLK_NUM; k++) begin : g_en
    logic en_f;
    logic en_ff;

    if (k == 0) begin : g_ref
      // reference comes up enabled, so o_clk runs in reset
      always_ff @(posedge i_clk[k] or negedge src_rst_n[k]) begin
        if (!src_rst_n[k]) begin
          en_f  <= 1'b1;
          en_ff <= 1'b1;
        end else begin
          en_f  <= req[k];
          en_ff <= en_f;
        end
      end
    end else begin : g_src
      // flop clear, from reset or a fault
      logic clr_n;

      // a fault releases that source at once
      assign clr_n = ~clk_fail[k] & src_rst_n[k];

      // other sources start off
      always_ff @(posedge i_clk[k] or negedge clr_n) begin
        if (!clr_n) begin
          en_f  <= 1'b0;
          en_ff <= 1'b0;
        end else begin
          en_f  <= req[k];
          en_ff <= en_f;
        end
      end
    end

    // second stage gates the clock
    assign active[k] = en_ff;
  end

  // **************************************************
  // output clock
  // **************************************************
  // at most one enable is high outside of a handover gap
  assign o_clk = |(i_clk & active);

endmodule

// File: rtl/clk_status.sv
// **************************************************
// switch status
// syncs the active enables to the reference,
// reports the active source and switch completion
// **************************************************
module clk_status (
  input  logic                             i_clk0,
  input  logic                             rst_n,
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] active,
  input  logic [clk_ctrl_pkg::SEL_W-1:0]   sel,
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] clk_fail,
  input  logic                             auto_en,
  input  logic                             bad_op,
  output clk_ctrl_pkg::clk_status_t        status,
  output logic                             switch_done
);

  logic [clk_ctrl_pkg::CLK_NUM-1:0] active_s1;
  logic [clk_ctrl_pkg::CLK_NUM-1:0] active_s2;
  // encoded second stage, valid when any bit is set
  logic [clk_ctrl_pkg::SEL_W-1:0]   enc_idx;
  // last settled active source
  logic [clk_ctrl_pkg::SEL_W-1:0]   act_idx;

  // reset value matches the switch, source 0 on
  always_ff @(posedge i_clk0 or negedge rst_n) begin
    if (!rst_n) begin
      active_s1 <= {{(clk_ctrl_pkg::CLK_NUM-1){1'b0}}, 1'b1};
      active_s2 <= {{(clk_ctrl_pkg::CLK_NUM-1){1'b0}}, 1'b1};
    end else begin
      active_s1 <= active;
      active_s2 <= active_s1;
    end
  end

  // one-hot to index
  always_comb begin
    enc_idx = '0;
    for (int i = 0; i < clk_ctrl_pkg::CLK_NUM; i++) begin
      if (active_s2[i]) begin
        enc_idx = i[clk_ctrl_pkg::SEL_W-1:0];
      end
    end
  end

  // hold through the gap where no enable is set
  always_ff @(posedge i_clk0 or negedge rst_n) begin
    if (!rst_n) begin
      act_idx <= '0;
    end else if (|active_s2) begin
      act_idx <= enc_idx;
    end
  end

  // one cycle, act_idx catches up on the next edge
  assign switch_done = (|active_s2) && (enc_idx != act_idx) && (enc_idx == sel);

  // **************************************************
  // status word
  // **************************************************
  assign status.active  = act_idx;
  assign status.req     = sel;
  assign status.fail    = clk_fail;
  assign status.auto_en = auto_en;
  assign status.bad_op  = bad_op;

endmodule

// File: rtl/clk_ctrl_top.sv
// **************************************************
// clock management unit top
// command decode, loss monitors, glitch-free switch
// and status reporting
// **************************************************
module clk_ctrl_top (
  input  logic [clk_ctrl_pkg::CLK_NUM-1:0] i_clk,
  input  logic                             rst_n,
  input  clk_ctrl_pkg::clk_cmd_t           cmd,
  input  logic                             cmd_valid,
  output logic                             o_clk,
  output clk_ctrl_pkg::clk_status_t        status,
  output logic                             switch_done
);

  // per-domain resets, bit 0 drives the control logic
  logic [clk_ctrl_pkg::CLK_NUM-1:0] src_rst_n;
  // sticky faults in the reference domain
  logic [clk_ctrl_pkg::CLK_NUM-1:0] clk_fail;
  // second-stage enables, one per source domain
  logic [clk_ctrl_pkg::CLK_NUM-1:0] active;
  logic [clk_ctrl_pkg::SEL_W-1:0]   sel;
  logic                             auto_en;
  logic                             clear_fail;
  logic                             bad_op;

  rst_sync_bank u_rst_sync (
    .i_clk     (i_clk),
    .rst_n     (rst_n),
    .src_rst_n (src_rst_n)
  );

  clk_cmd_decode u_decode (
    .i_clk0     (i_clk[0]),
    .rst_n      (src_rst_n[0]),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .clk_fail   (clk_fail),
    .sel        (sel),
    .auto_en    (auto_en),
    .clear_fail (clear_fail),
    .bad_op     (bad_op)
  );

  clk_fail_monitor u_monitor (
    .i_clk      (i_clk),
    .src_rst_n  (src_rst_n),
    .rst_n      (src_rst_n[0]),
    .clear_fail (clear_fail),
    .clk_fail   (clk_fail)
  );

  sys_clk_switch u_switch (
    .i_clk     (i_clk),
    .clk_fail  (clk_fail),
    .sel       (sel),
    .src_rst_n (src_rst_n),
    .o_clk     (o_clk),
    .active    (active)
  );

  clk_status u_status (
    .i_clk0      (i_clk[0]),
    .rst_n       (src_rst_n[0]),
    .active      (active),
    .sel         (sel),
    .clk_fail    (clk_fail),
    .auto_en     (auto_en),
    .bad_op      (bad_op),
    .status      (status),
    .switch_done (switch_done)
  );

endmodule

// File: testbench/clk_ctrl_tb.sv
// **************************************************
// clock management unit testbench
// random selects, mid-switch reselect, failover on
// a stopped source, fault clear and reserved opcode
// **************************************************
module clk_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // half periods of the four sources in ns
  localparam longint HALF_NS [4] = '{4, 5, 7, 11};
  // worst switch plus one period measurement, with margin
  localparam longint SWITCH_NS = 400;
  localparam longint FAILOVER_NS = (clk_ctrl_pkg::FAIL_WINDOW + 4) * 8 + SWITCH_NS;
  localparam int N_RANDOM = 10;

  logic clk0 = 1'b0;
  logic clk1 = 1'b0;
  logic clk2 = 1'b0;
  logic clk3 = 1'b0;
  // halts source 2 for the failover test
  logic stop_clk2 = 1'b0;

  logic [clk_ctrl_pkg::CLK_NUM-1:0] i_clk;
  logic                             rst_n;
  clk_ctrl_pkg::clk_cmd_t           cmd;
  logic                             cmd_valid;
  logic                             o_clk;
  clk_ctrl_pkg::clk_status_t        status;
  logic                             switch_done;

  int                               seed;
  // source o_clk runs from once the last switch settled
  logic [clk_ctrl_pkg::SEL_W-1:0]   cur;
  // shortest legal o_clk phase right now
  longint                           min_phase = 4;
  bit                               check_phases = 1'b0;
  bit                               have_edge = 1'b0;
  logic                             o_clk_lvl = 1'b0;
  longint                           last_edge = 0;

  // **************************************************
  // source clocks: 8, 10, 14 and 22 ns
  // **************************************************
  always #4 clk0 = ~clk0;
  always #5 clk1 = ~clk1;
  always #7 begin
    if (!stop_clk2) begin
      clk2 = ~clk2;
    end
  end
  always #11 clk3 = ~clk3;

  assign i_clk = {clk3, clk2, clk1, clk0};

  clk_ctrl_top dut_i (
    .i_clk       (i_clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .o_clk       (o_clk),
    .status      (status),
    .switch_done (switch_done)
  );

  task automatic report_mismatch(string sig, longint exp, longint act);
    $display("ERR t=%0t %s expected %0d got %0d", $time, sig, exp, act);
    $display("Test FAILED");
    $fatal(1);
  endtask

  function automatic longint shorter_of(longint a, longint b);
    return (a < b) ? a : b;
  endfunction

  // source index step places further on, wrapping
  function automatic logic [clk_ctrl_pkg::SEL_W-1:0] step_src(
    logic [clk_ctrl_pkg::SEL_W-1:0] s, int step);
    int v;
    v = (int'(s) + step) % clk_ctrl_pkg::CLK_NUM;
    return v[clk_ctrl_pkg::SEL_W-1:0];
  endfunction

  // one strobe cycle on the reference clock
  task automatic send_cmd(clk_ctrl_pkg::clk_op_e op, logic [clk_ctrl_pkg::SEL_W-1:0] src);
    @(posedge clk0);
    cmd.op    <= op;
    cmd.src   <= src;
    cmd_valid <= 1'b1;
    @(posedge clk0);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clk0);
    while (!switch_done) begin
      @(negedge clk0);
    end
  endtask

  task automatic check_period(logic [clk_ctrl_pkg::SEL_W-1:0] src);
    longint t0;
    @(posedge o_clk);
    t0 = longint'($time);
    @(posedge o_clk);
    assert (longint'($time) - t0 == 2 * HALF_NS[src])
      else report_mismatch("o_clk period", 2 * HALF_NS[src], longint'($time) - t0);
  endtask

  // done, status one edge later, then the new period
  task automatic finish_switch(logic [clk_ctrl_pkg::SEL_W-1:0] src);
    wait_done();
    @(negedge clk0);
    assert (status.active == src) else report_mismatch("status.active", src, status.active);
    check_period(src);
    cur       = src;
    min_phase = HALF_NS[src];
  endtask

  task automatic select_source(logic [clk_ctrl_pkg::SEL_W-1:0] src);
    min_phase = shorter_of(HALF_NS[cur], HALF_NS[src]);
    send_cmd(clk_ctrl_pkg::OP_SELECT, src);
    finish_switch(src);
  endtask

  // **************************************************
  // o_clk phase width watch
  // **************************************************
  always begin : phase_watch
    longint width;
    @(o_clk);
    // a change undone within the same time step has no width
    #0.1;
    if (o_clk != o_clk_lvl) begin
      width = longint'($time) - last_edge;
      if (have_edge && check_phases) begin
        assert (width >= min_phase) else report_mismatch("o_clk phase", min_phase, width);
      end
      have_edge = 1'b1;
      last_edge = longint'($time);
      o_clk_lvl = o_clk;
    end
  end

  // done lasts a single reference cycle
  assert property (@(posedge clk0) disable iff (!rst_n) switch_done |=> !switch_done)
    else report_mismatch("switch_done", 0, 1);

  // **************************************************
  // stimulus
  // **************************************************
  initial begin
    logic [31:0]                    rnd;
    logic [clk_ctrl_pkg::SEL_W-1:0] src;
    logic [clk_ctrl_pkg::SEL_W-1:0] mid;
    logic [clk_ctrl_pkg::SEL_W-1:0] req_before;
    int                             n;
    seed      = 32'h60da;
    cur       = '0;
    rst_n     = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    repeat (5) @(posedge clk0);
    rst_n <= 1'b1;
    // every domain leaves reset, slowest takes 44 ns
    repeat (10) @(negedge clk0);
    check_phases = 1'b1;

    // reference runs after reset
    assert (status.active == 0) else report_mismatch("status.active", 0, status.active);
    assert (status.fail == '0) else report_mismatch("status.fail", 0, status.fail);
    assert (status.auto_en == 1'b0) else report_mismatch("status.auto_en", 0, 1);
    check_period('0);

    // random selects, always to a new source
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd = $random(seed);
      src = rnd[clk_ctrl_pkg::SEL_W-1:0];
      if (src == cur) begin
        src = step_src(src, 1);
      end
      select_source(src);
    end

    // reselect before the first switch can finish
    for (int i = 0; i < 2; i++) begin
      mid       = step_src(cur, 1);
      src       = step_src(cur, 2);
      min_phase = shorter_of(HALF_NS[cur], shorter_of(HALF_NS[mid], HALF_NS[src]));
      send_cmd(clk_ctrl_pkg::OP_SELECT, mid);
      send_cmd(clk_ctrl_pkg::OP_SELECT, src);
      finish_switch(src);
    end

    // **************************************************
    // failover from a stopped source 2
    // **************************************************
    send_cmd(clk_ctrl_pkg::OP_AUTO_ON, '0);
    @(negedge clk0);
    assert (status.auto_en == 1'b1) else report_mismatch("status.auto_en", 1, 0);
    if (cur != 2) begin
      select_source(2);
    end
    min_phase = shorter_of(HALF_NS[2], HALF_NS[0]);
    stop_clk2 = 1'b1;
    n = 0;
    while (!status.fail[2] && n < clk_ctrl_pkg::FAIL_WINDOW + 6) begin
      @(negedge clk0);
      n++;
    end
    assert (status.fail[2]) else report_mismatch("status.fail[2]", 1, 0);
    finish_switch('0);
    assert (status.req == 0) else report_mismatch("status.req", 0, status.req);

    // restart, clear the fault, then a reserved code
    stop_clk2 = 1'b0;
    repeat (12) @(negedge clk0);
    send_cmd(clk_ctrl_pkg::OP_CLEAR_FAIL, '0);
    repeat (3) @(negedge clk0);
    assert (status.fail == '0) else report_mismatch("status.fail", 0, status.fail);
    req_before = status.req;
    send_cmd(clk_ctrl_pkg::clk_op_e'(3'd6), step_src(req_before, 1));
    repeat (2) @(negedge clk0);
    assert (status.bad_op == 1'b1) else report_mismatch("status.bad_op", 1, 0);
    assert (status.req == req_before) else report_mismatch("status.req", req_before, status.req);
    // source 2 runs again, no new fault
    repeat (clk_ctrl_pkg::FAIL_WINDOW + 8) @(negedge clk0);
    assert (status.fail == '0) else report_mismatch("status.fail", 0, status.fail);

    $display("Test OK");
    $finish;
  end

  // watchdog, 20 switches plus one failover
  initial begin
    #(20 * SWITCH_NS + FAILOVER_NS);
    $display("watchdog expired before the test sequence completed");
    $display("Test FAILED");
    $fatal(1);
  end

endmodule

// File: clk_ctrl.f
rtl/clk_ctrl_pkg.sv
rtl/rst_sync_bank.sv
rtl/clk_cmd_decode.sv
rtl/clk_fail_monitor.sv
rtl/sys_clk_switch.sv
rtl/clk_status.sv
rtl/clk_ctrl_top.sv
testbench/clk_ctrl_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = clk_ctrl_tb
FILELIST = clk_ctrl.f
OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
